//--- lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// fetch address after reset
`define LC3B_RESET_PC 16'h0000

// depth of the instruction and data memory models, in words
`define LC3B_MEM_WORDS 256

`endif

//--- lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;   // data or address
    typedef logic [2:0]  lc3b_reg;    // register index
    typedef logic [2:0]  lc3b_nzp;    // one-hot n, z, p

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // alu_pass is zero so an all-zero control word does nothing
    typedef enum logic [1:0] {
        alu_pass = 2'b00,
        alu_add  = 2'b01,
        alu_and  = 2'b10,
        alu_not  = 2'b11
    } alu_ops;

    typedef struct packed {
        logic       branch;                    // if
        logic       regfile_sr1_mux_sel;       // id
        logic       regfile_sr2_mux_sel;
        logic       pc_adder_mux_sel;          // ex
        logic [2:0] general_alu_mux_sel;
        alu_ops     general_alu_op;
        logic       cc_load;                   // mem
        logic [1:0] cc_gen_mux_sel;
        logic       br_en_load;
        logic       internal_mdr_load;
        logic       data_memory_write_enable;
        logic [1:0] data_memory_addr_mux_sel;
        logic [1:0] data_memory_byte_sel;
        logic [2:0] regfile_data_mux_sel;      // wb
        logic       regfile_dest_mux_sel;
        logic       regfile_load;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_word         pc;       // incremented pc of this instruction
        lc3b_word         ir;
        lc3b_control_word ctrl;
        lc3b_word         a;        // sr1 value
        lc3b_word         b;        // sr2 value, store data for STR
        lc3b_word         result;   // alu result or branch target
        lc3b_word         mdr;
    } lc3b_stage;

endpackage

//--- control_rom.sv
`timescale 1ns/100ps

module control_rom (
    input  lc3b_types::lc3b_word         ir_in,
    output lc3b_types::lc3b_control_word control_out
);
    import lc3b_types::*;

    lc3b_opcode opcode;
    logic       imm_form;

    assign opcode   = lc3b_opcode'(ir_in[15:12]);
    assign imm_form = ir_in[5];   // ADD/AND second operand is imm5

    always_comb begin
        control_out = '0;   // every field defaults to no effect

        case (opcode)
            op_add: begin
                control_out.regfile_sr1_mux_sel = 1'b0;   // sr1 = ir[8:6]
                control_out.regfile_sr2_mux_sel = 1'b0;   // sr2 = ir[2:0]
                if (imm_form) begin
                    control_out.general_alu_mux_sel = 3'b010;   // imm5
                end else begin
                    control_out.general_alu_mux_sel = 3'b000;   // sr2
                end
                control_out.general_alu_op       = alu_add;
                control_out.cc_load              = 1'b1;
                control_out.cc_gen_mux_sel       = 2'b01;    // cc from alu
                control_out.regfile_data_mux_sel = 3'b101;   // alu result
                control_out.regfile_dest_mux_sel = 1'b0;     // dr = ir[11:9]
                control_out.regfile_load         = 1'b1;
            end

            op_and: begin
                control_out.regfile_sr1_mux_sel = 1'b0;
                control_out.regfile_sr2_mux_sel = 1'b0;
                if (imm_form) begin
                    control_out.general_alu_mux_sel = 3'b010;
                end else begin
                    control_out.general_alu_mux_sel = 3'b000;
                end
                control_out.general_alu_op       = alu_and;
                control_out.cc_load              = 1'b1;
                control_out.cc_gen_mux_sel       = 2'b01;
                control_out.regfile_data_mux_sel = 3'b101;
                control_out.regfile_dest_mux_sel = 1'b0;
                control_out.regfile_load         = 1'b1;
            end

            op_not: begin
                control_out.regfile_sr1_mux_sel  = 1'b0;
                control_out.general_alu_op       = alu_not;   // ignores operand b
                control_out.cc_load              = 1'b1;
                control_out.cc_gen_mux_sel       = 2'b01;
                control_out.regfile_data_mux_sel = 3'b101;
                control_out.regfile_dest_mux_sel = 1'b0;
                control_out.regfile_load         = 1'b1;
            end

            op_ldr: begin
                control_out.regfile_sr1_mux_sel      = 1'b0;     // base register
                control_out.general_alu_mux_sel      = 3'b100;   // offset6 << 1
                control_out.general_alu_op           = alu_add;
                control_out.cc_load                  = 1'b1;
                control_out.cc_gen_mux_sel           = 2'b10;    // cc from loaded word
                control_out.internal_mdr_load        = 1'b1;
                control_out.data_memory_write_enable = 1'b0;
                control_out.data_memory_addr_mux_sel = 2'b01;    // address from alu
                control_out.data_memory_byte_sel     = 2'b11;    // full word
                control_out.regfile_data_mux_sel     = 3'b010;   // mdr
                control_out.regfile_dest_mux_sel     = 1'b0;
                control_out.regfile_load             = 1'b1;
            end

            op_str: begin
                control_out.regfile_sr1_mux_sel      = 1'b0;
                control_out.regfile_sr2_mux_sel      = 1'b1;     // sr = ir[11:9]
                control_out.general_alu_mux_sel      = 3'b100;
                control_out.general_alu_op           = alu_add;
                control_out.data_memory_write_enable = 1'b1;
                control_out.data_memory_addr_mux_sel = 2'b01;
                control_out.data_memory_byte_sel     = 2'b11;
            end

            op_br: begin
                control_out.branch           = 1'b1;
                control_out.pc_adder_mux_sel = 1'b0;   // offset9
                control_out.br_en_load       = 1'b1;   // nzp test in mem
            end

            // outside the subset, retires as a no-op
            default: begin
                control_out = '0;
            end
        endcase
    end

endmodule : control_rom

//--- regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word in,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);
    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // write-through so the reader in ID sees the value WB is writing
    assign reg_a = (load && (dest == sr1)) ? in : regs[sr1];
    assign reg_b = (load && (dest == sr2)) ? in : regs[sr2];

endmodule : regfile

//--- hazard_detect.sv
`timescale 1ns/100ps

module hazard_detect (
    input  lc3b_types::lc3b_reg sr1,
    input  lc3b_types::lc3b_reg sr2,
    input  logic                use_sr1,
    input  logic                use_sr2,
    input  lc3b_types::lc3b_reg ex_dest,
    input  logic                ex_load,     // already gated by ex valid
    input  lc3b_types::lc3b_reg mem_dest,
    input  logic                mem_load,    // already gated by mem valid
    output logic                stall
);

    logic sr1_ex_hit;
    logic sr1_mem_hit;
    logic sr2_ex_hit;
    logic sr2_mem_hit;

    // WB needs no compare, the regfile writes through
    assign sr1_ex_hit  = use_sr1 && ex_load  && (sr1 == ex_dest);
    assign sr1_mem_hit = use_sr1 && mem_load && (sr1 == mem_dest);
    assign sr2_ex_hit  = use_sr2 && ex_load  && (sr2 == ex_dest);
    assign sr2_mem_hit = use_sr2 && mem_load && (sr2 == mem_dest);

    assign stall = sr1_ex_hit | sr1_mem_hit | sr2_ex_hit | sr2_mem_hit;

endmodule : hazard_detect

//--- lc3b_pipeline.sv
`timescale 1ns/100ps
`include "lc3b_config.svh"

module lc3b_pipeline (
    input  logic                 clk,
    input  logic                 arst_n,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    input  lc3b_types::lc3b_word dmem_rdata
);
    import lc3b_types::*;

    lc3b_word         pc;
    lc3b_word         pc_plus2;
    lc3b_word         pc_next;
    lc3b_stage        if_id;
    lc3b_stage        id_ex;
    lc3b_stage        ex_mem;
    lc3b_stage        mem_wb;
    lc3b_stage        if_id_next;
    lc3b_stage        id_ex_next;
    lc3b_stage        ex_mem_next;
    lc3b_stage        mem_wb_next;
    lc3b_control_word id_ctrl;
    lc3b_opcode       id_opcode;
    lc3b_reg          id_sr1;
    lc3b_reg          id_sr2;
    lc3b_word         reg_a;
    lc3b_word         reg_b;
    logic             use_sr1;
    logic             use_sr2;
    logic             hazard_stall;
    logic             stall;
    lc3b_word         alu_b;
    lc3b_word         alu_out;
    lc3b_word         pc_adder_out;
    lc3b_word         ex_result;
    lc3b_word         mem_value;
    lc3b_nzp          cc;
    lc3b_nzp          cc_gen;
    logic             br_taken;
    logic             wb_load;
    lc3b_reg          wb_dest;
    lc3b_word         wb_data;

    function automatic lc3b_reg dest_of(input lc3b_stage s);
        return s.ir[11:9];
    endfunction

    assign imem_addr = pc;
    assign pc_plus2  = pc + 16'd2;

    // decode
    control_rom control_rom_i (
        .ir_in       (if_id.ir),
        .control_out (id_ctrl)
    );

    assign id_opcode = lc3b_opcode'(if_id.ir[15:12]);
    assign id_sr1    = if_id.ir[8:6];
    assign id_sr2    = id_ctrl.regfile_sr2_mux_sel ? if_id.ir[11:9] : if_id.ir[2:0];
    assign use_sr1   = if_id.valid &&
                       (id_ctrl.regfile_load || id_ctrl.data_memory_write_enable);
    assign use_sr2   = if_id.valid && (id_ctrl.regfile_sr2_mux_sel ||
                       ((id_opcode == op_add || id_opcode == op_and) && !if_id.ir[5]));

    regfile regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (wb_load),
        .sr1    (id_sr1),
        .sr2    (id_sr2),
        .dest   (wb_dest),
        .in     (wb_data),
        .reg_a  (reg_a),
        .reg_b  (reg_b)
    );

    hazard_detect hazard_detect_i (
        .sr1      (id_sr1),
        .sr2      (id_sr2),
        .use_sr1  (use_sr1),
        .use_sr2  (use_sr2),
        .ex_dest  (dest_of(id_ex)),
        .ex_load  (id_ex.valid && id_ex.ctrl.regfile_load),
        .mem_dest (dest_of(ex_mem)),
        .mem_load (ex_mem.valid && ex_mem.ctrl.regfile_load),
        .stall    (hazard_stall)
    );

    // a taken branch flushes ID anyway, so it overrides the stall
    assign stall = hazard_stall && !br_taken;

    // execute
    always_comb begin
        case (id_ex.ctrl.general_alu_mux_sel)
            3'b010:  alu_b = {{11{id_ex.ir[4]}}, id_ex.ir[4:0]};          // imm5
            3'b100:  alu_b = {{9{id_ex.ir[5]}}, id_ex.ir[5:0], 1'b0};     // offset6 words
            default: alu_b = id_ex.b;
        endcase
        case (id_ex.ctrl.general_alu_op)
            alu_add: alu_out = id_ex.a + alu_b;
            alu_and: alu_out = id_ex.a & alu_b;
            alu_not: alu_out = ~id_ex.a;
            default: alu_out = alu_b;
        endcase
    end

    assign pc_adder_out = id_ex.pc + {{6{id_ex.ir[8]}}, id_ex.ir[8:0], 1'b0};   // offset9 words
    assign ex_result    = id_ex.ctrl.branch ? pc_adder_out : alu_out;

    // memory
    assign dmem_addr  = (ex_mem.ctrl.data_memory_addr_mux_sel == 2'b00) ? ex_mem.pc
                                                                        : ex_mem.result;
    assign dmem_wdata = ex_mem.b;
    assign dmem_we    = ex_mem.valid && ex_mem.ctrl.data_memory_write_enable &&
                        (ex_mem.ctrl.data_memory_byte_sel == 2'b11);   // word writes only

    assign mem_value = (ex_mem.ctrl.cc_gen_mux_sel == 2'b10) ? dmem_rdata : ex_mem.result;
    assign cc_gen    = mem_value[15] ? 3'b100 : ((mem_value == '0) ? 3'b010 : 3'b001);
    assign br_taken  = ex_mem.valid && ex_mem.ctrl.branch && ex_mem.ctrl.br_en_load &&
                       ((ex_mem.ir[11:9] & cc) != 3'b000);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc <= 3'b010;   // z
        end else if (ex_mem.valid && ex_mem.ctrl.cc_load) begin
            cc <= cc_gen;
        end
    end

    // writeback
    assign wb_load = mem_wb.valid && mem_wb.ctrl.regfile_load;
    assign wb_dest = dest_of(mem_wb);
    always_comb begin
        case (mem_wb.ctrl.regfile_data_mux_sel)
            3'b010:  wb_data = mem_wb.mdr;
            3'b101:  wb_data = mem_wb.result;
            default: wb_data = mem_wb.pc;   // link value
        endcase
    end

    // next state of pc and stage registers
    always_comb begin
        pc_next     = pc;
        if_id_next  = if_id;    // hold on stall
        id_ex_next  = '0;       // bubble unless ID advances
        ex_mem_next = '0;
        mem_wb_next = ex_mem;
        if (!stall) begin
            pc_next          = pc_plus2;
            if_id_next       = '0;
            if_id_next.valid = 1'b1;
            if_id_next.pc    = pc_plus2;
            if_id_next.ir    = imem_rdata;
            if (if_id.valid) begin
                id_ex_next      = if_id;
                id_ex_next.ctrl = id_ctrl;
                id_ex_next.a    = reg_a;
                id_ex_next.b    = reg_b;
            end
        end
        if (id_ex.valid) begin
            ex_mem_next        = id_ex;
            ex_mem_next.result = ex_result;
        end
        mem_wb_next.mdr = ex_mem.ctrl.internal_mdr_load ? dmem_rdata : ex_mem.mdr;
        if (br_taken) begin
            pc_next     = ex_mem.result;   // target from the pc adder
            if_id_next  = '0;
            id_ex_next  = '0;
            ex_mem_next = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= `LC3B_RESET_PC;
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            pc     <= pc_next;
            if_id  <= if_id_next;
            id_ex  <= id_ex_next;
            ex_mem <= ex_mem_next;
            mem_wb <= mem_wb_next;
        end
    end

endmodule : lc3b_pipeline

//--- lc3b_chk.sv
`timescale 1ns/100ps
`include "lc3b_config.svh"

module lc3b_chk (
    input  logic                  clk,
    input  logic                  arst_n,
    input  lc3b_types::lc3b_word  imem_addr,
    input  logic                  dmem_we,
    input  logic                  stall,
    input  lc3b_types::lc3b_stage mem_stage
);
    import lc3b_types::*;

    int assert_failures = 0;   // read by the testbench

    // pc parked and no write while reset is held
    reset_state_a : assert property (@(posedge clk)
        !arst_n |-> (imem_addr == `LC3B_RESET_PC) && !dmem_we)
        else begin
            assert_failures = assert_failures + 1;
            $error("pc or dmem_we wrong while reset is held");
        end

    first_fetch_a : assert property (@(posedge clk)
        $rose(arst_n) |-> (imem_addr == `LC3B_RESET_PC) && !dmem_we)
        else begin
            assert_failures = assert_failures + 1;
            $error("first fetch after reset is not at the reset pc");
        end

    stall_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> $stable(imem_addr))
        else begin
            assert_failures = assert_failures + 1;
            $error("fetch address moved during a stall");
        end

    // a write needs a live STR in MEM
    write_valid_a : assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> mem_stage.valid && (lc3b_opcode'(mem_stage.ir[15:12]) == op_str))
        else begin
            assert_failures = assert_failures + 1;
            $error("dmem_we high without a valid STR in the MEM stage");
        end

endmodule : lc3b_chk

//--- tb_lc3b.sv
`timescale 1ns/100ps
`include "lc3b_config.svh"

module tb_lc3b;
    import lc3b_types::*;

    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 10;

    logic     clk = 1'b0;
    logic     arst_n = 1'b0;
    lc3b_word imem_addr;
    lc3b_word imem_rdata;
    lc3b_word dmem_addr;
    lc3b_word dmem_wdata;
    logic     dmem_we;
    lc3b_word dmem_rdata;

    lc3b_word imem [`LC3B_MEM_WORDS];
    lc3b_word dmem [`LC3B_MEM_WORDS];
    lc3b_word model_mem [`LC3B_MEM_WORDS];   // data memory as the model sees it
    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    int       prog_len = 0;
    int       store_idx = 0;
    int       cycle_count = 0;
    int       timeout_cycles = 0;
    int       seed;

    lc3b_pipeline dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    bind lc3b_pipeline lc3b_chk chk_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .dmem_we   (dmem_we),
        .stall     (stall),
        .mem_stage (ex_mem)
    );

    always #5 clk = ~clk;

    assign imem_rdata = imem[imem_addr[8:1]];   // word index of byte address
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[8:1]] = dmem_wdata;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic flag_mismatch(input string name, input lc3b_word expected,
                                 input lc3b_word got);
        abort_run($sformatf("Fail at %0d ns: %s expected %h got %h",
                            $time, name, expected, got));
    endtask

    function automatic lc3b_word alu_rr(input lc3b_opcode op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_word alu_ri(input lc3b_opcode op, input lc3b_reg dr,
                                        input lc3b_reg sr1, input logic [4:0] imm);
        return {op, dr, sr1, 1'b1, imm};
    endfunction

    function automatic lc3b_word not_of(input lc3b_reg dr, input lc3b_reg sr);
        return {op_not, dr, sr, 6'b111111};
    endfunction

    function automatic lc3b_word mem_access(input lc3b_opcode op, input lc3b_reg r,
                                            input lc3b_reg base, input logic [5:0] off);
        return {op, r, base, off};
    endfunction

    function automatic lc3b_word branch_to(input lc3b_nzp nzp, input logic [8:0] off);
        return {op_br, nzp, off};
    endfunction

    function automatic lc3b_nzp cc_of(input lc3b_word v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == 16'h0000) ? 3'b010 : 3'b001;
    endfunction

    task automatic emit(input lc3b_word w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_program();
        emit(alu_ri(op_add, 3'd6, 3'd0, 5'd8));           // r6 = base 8
        emit(mem_access(op_ldr, 3'd1, 3'd6, 6'd0));       // use at distance 1
        emit(mem_access(op_ldr, 3'd2, 3'd6, 6'd1));
        emit(alu_rr(op_add, 3'd3, 3'd1, 3'd2));           // distances 2 and 1
        emit(mem_access(op_str, 3'd3, 3'd6, 6'd10));
        emit(alu_rr(op_and, 3'd4, 3'd1, 3'd2));
        emit(mem_access(op_str, 3'd4, 3'd6, 6'd11));
        emit(alu_ri(op_and, 3'd5, 3'd3, 5'b11010));       // and with -6
        emit(not_of(3'd7, 3'd5));
        emit(mem_access(op_str, 3'd5, 3'd6, 6'd12));
        emit(mem_access(op_str, 3'd7, 3'd6, 6'd13));
        emit(alu_ri(op_add, 3'd1, 3'd1, 5'b11111));
        emit(alu_ri(op_add, 3'd1, 3'd1, 5'd7));
        emit(alu_rr(op_add, 3'd2, 3'd1, 3'd1));
        emit(mem_access(op_str, 3'd2, 3'd6, 6'd14));
        emit(mem_access(op_ldr, 3'd3, 3'd6, 6'd10));      // reads back an earlier store
        emit(alu_ri(op_add, 3'd3, 3'd3, 5'd3));           // load-use
        emit(mem_access(op_str, 3'd3, 3'd6, 6'd15));
        emit(mem_access(op_ldr, 3'd4, 3'd6, 6'd2));
        emit(branch_to(3'b100, 9'd1));                    // outcome from the loaded sign
        emit(mem_access(op_str, 3'd4, 3'd6, 6'd16));
        emit(alu_ri(op_and, 3'd5, 3'd4, 5'd0));
        emit(branch_to(3'b010, 9'd3));                    // always taken here
        emit(mem_access(op_str, 3'd1, 3'd6, 6'd17));
        emit(mem_access(op_str, 3'd2, 3'd6, 6'd18));
        emit(mem_access(op_str, 3'd3, 3'd6, 6'd19));
        emit(alu_ri(op_add, 3'd5, 3'd5, 5'd5));
        emit(branch_to(3'b110, 9'd1));                    // never taken here
        emit(mem_access(op_str, 3'd5, 3'd6, 6'd20));
        emit({op_lea, 3'd1, 9'h005});                     // outside the subset
        emit({op_shf, 3'd2, 3'd2, 6'h11});
        emit(mem_access(op_str, 3'd1, 3'd6, 6'd21));
        emit(mem_access(op_str, 3'd2, 3'd6, 6'd22));
        emit(not_of(3'd0, 3'd4));
        emit(mem_access(op_str, 3'd0, 3'd6, 6'd23));
    endtask

    // ISA-level reference run, fills the expected store list
    task automatic run_model();
        lc3b_word regs_m [8];
        lc3b_word pc_m;
        lc3b_word ir;
        lc3b_word operand;
        lc3b_word addr;
        lc3b_nzp  cc_m;
        lc3b_reg  dr;
        int       steps;
        for (int i = 0; i < 8; i++) begin
            regs_m[i] = 16'h0000;
        end
        pc_m  = `LC3B_RESET_PC;
        cc_m  = 3'b010;
        steps = 0;
        while ((int'(pc_m[15:1]) < prog_len) && (steps < 4 * prog_len)) begin
            ir      = imem[pc_m[8:1]];
            dr      = ir[11:9];
            pc_m    = pc_m + 16'd2;
            steps++;
            operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs_m[ir[2:0]];
            addr    = regs_m[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            case (lc3b_opcode'(ir[15:12]))
                op_add: begin
                    regs_m[dr] = regs_m[ir[8:6]] + operand;
                    cc_m       = cc_of(regs_m[dr]);
                end
                op_and: begin
                    regs_m[dr] = regs_m[ir[8:6]] & operand;
                    cc_m       = cc_of(regs_m[dr]);
                end
                op_not: begin
                    regs_m[dr] = ~regs_m[ir[8:6]];
                    cc_m       = cc_of(regs_m[dr]);
                end
                op_ldr: begin
                    regs_m[dr] = model_mem[addr[8:1]];
                    cc_m       = cc_of(regs_m[dr]);
                end
                op_str: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs_m[dr]);
                    model_mem[addr[8:1]] = regs_m[dr];
                end
                op_br: begin
                    if ((ir[11:9] & cc_m) != 3'b000) begin
                        pc_m = pc_m + {{6{ir[8]}}, ir[8:0], 1'b0};
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    // store scoreboard, the write data is stable between edges
    always @(negedge clk) begin
        if (arst_n && dmem_we) begin
            assert (store_idx < exp_addr.size())
                else abort_run("a store appeared after the last expected one");
            assert (dmem_addr == exp_addr[store_idx])
                else flag_mismatch("dmem_addr", exp_addr[store_idx], dmem_addr);
            assert (dmem_wdata == exp_data[store_idx])
                else flag_mismatch("dmem_wdata", exp_data[store_idx], dmem_wdata);
            store_idx++;
        end
    end

    always @(negedge clk) begin
        if (dut_i.chk_i.assert_failures != 0) begin
            abort_run("an assertion in the bound checker failed");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    always @(negedge clk) begin
        if (cycle_count >= timeout_cycles) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                                cycle_count, store_idx, exp_addr.size()));
        end
    end

    initial begin
        seed = 61;
        load_program();
        for (int i = prog_len; i < `LC3B_MEM_WORDS; i++) begin
            imem[i] = {op_shf, 4'h0, 8'(i)};   // no-op filler tagged with its index
        end
        for (int i = 0; i < `LC3B_MEM_WORDS; i++) begin
            dmem[i]      = 16'($random(seed));
            model_mem[i] = dmem[i];
        end
        run_model();
        timeout_cycles = RESET_CYCLES + 6 * prog_len + 50;

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        while (store_idx < exp_addr.size()) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);

        if (dut_i.chk_i.assert_failures != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : tb_lc3b

//--- filelist.f
+incdir+.
lc3b_types.sv
control_rom.sv
regfile.sv
hazard_detect.sv
lc3b_pipeline.sv
lc3b_chk.sv
tb_lc3b.sv

//--- Makefile
TOP := tb_lc3b

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --assert --top-module $(TOP) -f filelist.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
